/* common/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data and address width
`define CPU_WORD_W 32

// general purpose registers, r0 included
`define CPU_NREGS 16

// first fetch address
`define CPU_RESET_PC 32'h0000_0000

`endif

/* common/cpu_pkg.sv */
`include "cpu_macros.svh"

package cpu_pkg;

  typedef logic [`CPU_WORD_W-1:0] word_t;
  typedef logic [$clog2(`CPU_NREGS)-1:0] reg_addr_t;
  typedef logic [3:0] opcode_t;     // ir[31:28]
  typedef logic [2:0] alu_func_t;
  typedef logic [1:0] mem_size_t;

  // datapath selects
  typedef logic [1:0] pc_sel_t;
  typedef logic mar_sel_t;
  typedef logic [1:0] mdr_sel_t;
  typedef logic [1:0] reg_sel_t;
  typedef logic alu1_sel_t;
  typedef logic alu2_sel_t;

  localparam opcode_t OP_ALU    = 4'd0;
  localparam opcode_t OP_CMP    = 4'd1;
  localparam opcode_t OP_ALUI   = 4'd2;
  localparam opcode_t OP_LUI    = 4'd3;
  localparam opcode_t OP_LOAD   = 4'd4;
  localparam opcode_t OP_STORE  = 4'd5;
  localparam opcode_t OP_BRANCH = 4'd6;
  localparam opcode_t OP_JUMP   = 4'd7; // anything above halts

  localparam alu_func_t ALU_ADD = 3'd0;
  localparam alu_func_t ALU_SUB = 3'd1;
  localparam alu_func_t ALU_AND = 3'd2;
  localparam alu_func_t ALU_OR  = 3'd3;
  localparam alu_func_t ALU_XOR = 3'd4;
  localparam alu_func_t ALU_SHL = 3'd5;
  localparam alu_func_t ALU_SHR = 3'd6;

  localparam mem_size_t SIZE_WORD = 2'd0;
  localparam mem_size_t SIZE_HALF = 2'd1;
  localparam mem_size_t SIZE_BYTE = 2'd2;

  // branch conditions, func field of opcode 6
  localparam logic [3:0] BR_ALWAYS = 4'd0;
  localparam logic [3:0] BR_EQ     = 4'd1;
  localparam logic [3:0] BR_NE     = 4'd2;
  localparam logic [3:0] BR_LT     = 4'd3;
  localparam logic [3:0] BR_GE     = 4'd4;
  localparam logic [3:0] BR_LTU    = 4'd5;

  localparam pc_sel_t   PC_HOLD    = 2'd0;
  localparam pc_sel_t   PC_INC     = 2'd1;
  localparam pc_sel_t   PC_ALU     = 2'd2;
  localparam mar_sel_t  MAR_HOLD   = 1'b0;
  localparam mar_sel_t  MAR_ALU    = 1'b1;
  localparam mdr_sel_t  MDR_HOLD   = 2'd0;
  localparam mdr_sel_t  MDR_LOAD   = 2'd1;
  localparam mdr_sel_t  MDR_REG2   = 2'd2;
  localparam reg_sel_t  REG_ALUVAL = 2'd0;
  localparam reg_sel_t  REG_MDR    = 2'd1;
  localparam reg_sel_t  REG_UVAL   = 2'd2;
  localparam alu1_sel_t ALU1_REG   = 1'b0;
  localparam alu1_sel_t ALU1_PC    = 1'b1;
  localparam alu2_sel_t ALU2_REG   = 1'b0;
  localparam alu2_sel_t ALU2_SVAL  = 1'b1;

  // condition codes
  typedef struct packed {
    logic carry; // unsigned borrow
    logic lt;    // signed less
    logic zero;
  } flags_t;

  typedef struct packed {
    pc_sel_t   pc_sel;
    mar_sel_t  mar_sel;
    mdr_sel_t  mdr_sel;
    reg_sel_t  reg_sel;
    alu1_sel_t alu1_sel;
    alu2_sel_t alu2_sel;
    alu_func_t alu_func;
    logic      ccr_write;
    logic      ir_write;
    logic      reg_write;
    logic      read2_from_rd;
    logic      addr_sel;
    mem_size_t mem_size;
  } ctrl_t;

  typedef enum logic [2:0] {
    FETCH,
    DECODE,
    EXEC,
    MEM,
    WB,
    HALT
  } ctrl_state_e;

endpackage

/* hdl/alu.sv */
`include "cpu_macros.svh"

module alu import cpu_pkg::*; (
  input  word_t     in1_i,
  input  word_t     in2_i,
  input  alu_func_t func_i,
  output word_t     out_o,
  output flags_t    flags_o
);

  localparam int MSB = `CPU_WORD_W - 1;
  localparam int SHW = $clog2(`CPU_WORD_W);

  word_t sum;
  logic [`CPU_WORD_W:0] diff;
  logic overflow;
  logic negative;

  assign sum  = in1_i + in2_i;
  assign diff = {1'b0, in1_i} - {1'b0, in2_i};

  always_comb begin
    overflow = 1'b0;
    case (func_i)
      ALU_ADD: begin
        out_o = sum;
        overflow = (in1_i[MSB] == in2_i[MSB]) && (sum[MSB] != in1_i[MSB]);
      end
      ALU_SUB: begin
        out_o = diff[MSB:0];
        overflow = (in1_i[MSB] != in2_i[MSB]) && (diff[MSB] != in1_i[MSB]);
      end
      ALU_AND: out_o = in1_i & in2_i;
      ALU_OR:  out_o = in1_i | in2_i;
      ALU_XOR: out_o = in1_i ^ in2_i;
      ALU_SHL: out_o = in1_i << in2_i[SHW-1:0];
      ALU_SHR: out_o = in1_i >> in2_i[SHW-1:0]; // logical
      default: out_o = '0;
    endcase
  end

  assign negative = out_o[MSB];

  assign flags_o.carry = diff[`CPU_WORD_W]; // borrow out of in1 - in2
  assign flags_o.lt    = negative ^ overflow;
  assign flags_o.zero  = (out_o == '0);

endmodule

/* hdl/register_file.sv */
`include "cpu_macros.svh"

module register_file import cpu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      write_i,
  input  reg_addr_t read1_i,
  input  reg_addr_t read2_i,
  input  reg_addr_t write_addr_i,
  input  word_t     write_data_i,
  output word_t     data1_o,
  output word_t     data2_o
);

  word_t regs [`CPU_NREGS];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write_i && write_addr_i != '0) begin // r0 stays zero
      regs[write_addr_i] <= write_data_i;
    end
  end

  assign data1_o = (read1_i == '0) ? '0 : regs[read1_i];
  assign data2_o = (read2_i == '0) ? '0 : regs[read2_i];

  // a write to an unknown index would corrupt the whole file in simulation
  write_addr_known: assert property (@(posedge clk_i) disable iff (rst_i)
    write_i |-> !$isunknown(write_addr_i));

endmodule

/* hdl/bus_lanes.sv */
module bus_lanes import cpu_pkg::*; (
  input  mem_size_t  size_i,
  input  logic [1:0] addr_low_i,
  input  word_t      store_i,
  input  word_t      readdata_i,
  input  logic       cyc_i,      // only checked by the alignment assertion
  output logic [3:0] byteenable_o,
  output word_t      writedata_o,
  output word_t      load_o
);

  logic [4:0] lane_shift;

  assign lane_shift = {addr_low_i, 3'b000};

  always_comb begin
    case (size_i)
      SIZE_WORD: begin
        byteenable_o = 4'b1111;
        writedata_o  = store_i;
        load_o       = readdata_i;
      end
      SIZE_HALF: begin
        if (addr_low_i[1]) begin // upper half
          byteenable_o = 4'b1100;
          writedata_o  = {store_i[15:0], 16'h0000};
          load_o       = {16'h0000, readdata_i[31:16]};
        end else begin
          byteenable_o = 4'b0011;
          writedata_o  = {16'h0000, store_i[15:0]};
          load_o       = {16'h0000, readdata_i[15:0]};
        end
      end
      SIZE_BYTE: begin
        byteenable_o = 4'b0001 << addr_low_i;
        writedata_o  = {24'h000000, store_i[7:0]} << lane_shift;
        load_o       = {24'h000000, 8'(readdata_i >> lane_shift)};
      end
      default: begin // no lanes for the unused size code
        byteenable_o = 4'b0000;
        writedata_o  = store_i;
        load_o       = readdata_i;
      end
    endcase
  end

  always_comb begin
    if (cyc_i) begin
      aligned: assert final ((size_i != SIZE_WORD || addr_low_i == 2'b00) &&
                             (size_i != SIZE_HALF || !addr_low_i[0]))
        else $error("misaligned bus access, size %0d addr low %b", size_i, addr_low_i);
    end
  end

endmodule

/* control/control.sv */
module control import cpu_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   ack_i,
  input  word_t  ir_i,
  input  flags_t ccr_i,
  output ctrl_t  ctrl_o,
  output logic   cyc_o,
  output logic   we_o,
  output logic   halt_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  opcode_t     opcode;
  logic [3:0]  func;
  logic        bus_done;
  logic        taken;

  assign opcode   = ir_i[31:28];
  assign func     = ir_i[27:24];
  assign bus_done = cyc_o & ack_i; // ack only counts inside a cycle

  always_comb begin
    case (func)
      BR_ALWAYS: taken = 1'b1;
      BR_EQ:     taken = ccr_i.zero;
      BR_NE:     taken = !ccr_i.zero;
      BR_LT:     taken = ccr_i.lt;
      BR_GE:     taken = !ccr_i.lt;
      BR_LTU:    taken = ccr_i.carry;
      default:   taken = 1'b0;
    endcase
  end

  always_comb begin
    ctrl_o = '0; // hold everything, alu adds, word size
    ctrl_o.read2_from_rd = (opcode == OP_STORE); // store data comes from rd
    state_d = state_q;
    case (state_q)
      FETCH: begin
        if (bus_done) begin
          ctrl_o.ir_write = 1'b1;
          ctrl_o.pc_sel = PC_INC;
          state_d = DECODE;
        end
      end
      DECODE: state_d = (opcode > OP_JUMP) ? HALT : EXEC;
      EXEC: begin
        state_d = FETCH;
        case (opcode)
          OP_ALU: begin
            ctrl_o.alu_func = func[2:0];
            state_d = WB;
          end
          OP_CMP: begin
            ctrl_o.alu_func = ALU_SUB;
            ctrl_o.ccr_write = 1'b1;
          end
          OP_ALUI: begin
            ctrl_o.alu_func = func[2:0];
            ctrl_o.alu2_sel = ALU2_SVAL;
            state_d = WB;
          end
          OP_LUI: state_d = WB;
          OP_LOAD, OP_STORE: begin
            ctrl_o.alu2_sel = ALU2_SVAL; // rs1 + sval
            ctrl_o.mar_sel = MAR_ALU;
            ctrl_o.mdr_sel = (opcode == OP_STORE) ? MDR_REG2 : MDR_HOLD;
            state_d = MEM;
          end
          OP_BRANCH: begin
            ctrl_o.alu1_sel = ALU1_PC; // pc already past the branch
            ctrl_o.alu2_sel = ALU2_SVAL;
            if (taken) ctrl_o.pc_sel = PC_ALU;
          end
          OP_JUMP: begin
            ctrl_o.alu2_sel = ALU2_SVAL;
            ctrl_o.pc_sel = PC_ALU;
          end
          default: state_d = HALT;
        endcase
      end
      MEM: begin
        ctrl_o.addr_sel = 1'b1;
        ctrl_o.mem_size = func[1:0];
        if (bus_done) begin
          if (opcode == OP_LOAD) begin
            ctrl_o.mdr_sel = MDR_LOAD;
            state_d = WB;
          end else begin
            state_d = FETCH;
          end
        end
      end
      WB: begin
        ctrl_o.reg_write = 1'b1;
        case (opcode)
          OP_LUI:  ctrl_o.reg_sel = REG_UVAL;
          OP_LOAD: ctrl_o.reg_sel = REG_MDR;
          default: ctrl_o.reg_sel = REG_ALUVAL;
        endcase
        state_d = FETCH;
      end
      default: state_d = HALT; // HALT is terminal
    endcase
  end

  // bus strobes registered from the next state
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= FETCH;
      cyc_o   <= 1'b0;
      we_o    <= 1'b0;
      halt_o  <= 1'b0;
    end else begin
      state_q <= state_d;
      cyc_o   <= (state_d == FETCH) || (state_d == MEM);
      we_o    <= (state_d == MEM) && (opcode == OP_STORE);
      halt_o  <= (state_d == HALT);
    end
  end

  // halt is never left and the bus stays idle
  no_cyc_in_halt: assert property (@(posedge clk_i) disable iff (rst_i)
    state_q == HALT |=> state_q == HALT && !cyc_o);

  // a write stays inside its cycle until the ack
  we_inside_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
    we_o && !ack_i |=> we_o && cyc_o);

endmodule

/* hdl/cpu_core.sv */
`include "cpu_macros.svh"

module cpu_core import cpu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       ack_i,
  input  word_t      readdata_i,
  output word_t      address_o,
  output word_t      writedata_o,
  output logic [3:0] byteenable_o,
  output logic       cyc_o,
  output logic       we_o,
  output logic       halt_o
);

  ctrl_t ctrl;

  // special registers
  word_t  pc_q;
  word_t  ir_q;
  word_t  mar_q;
  word_t  mdr_q;
  word_t  aluval_q;
  flags_t ccr_q;

  word_t     sval;
  word_t     uval;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t read2_addr;
  word_t     data1;
  word_t     data2;
  word_t     reg_wdata;
  word_t     alu_in1;
  word_t     alu_in2;
  word_t     alu_out;
  flags_t    alu_flags;
  word_t     load_data;

  // immediate is split around rd/rs1
  assign sval = {{16{ir_q[23]}}, ir_q[23:20], ir_q[11:0]};
  assign uval = {16'h0000, ir_q[23:20], ir_q[11:0]};
  assign rd   = ir_q[19:16];
  assign rs1  = ir_q[15:12];
  assign rs2  = ir_q[11:8];

  assign read2_addr = ctrl.read2_from_rd ? rd : rs2;
  assign address_o  = ctrl.addr_sel ? mar_q : pc_q;

  always_comb begin
    case (ctrl.reg_sel)
      REG_MDR:  reg_wdata = mdr_q;
      REG_UVAL: reg_wdata = uval;
      default:  reg_wdata = aluval_q;
    endcase
    alu_in1 = (ctrl.alu1_sel == ALU1_PC) ? pc_q : data1;
    alu_in2 = (ctrl.alu2_sel == ALU2_SVAL) ? sval : data2;
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      pc_q     <= `CPU_RESET_PC;
      ir_q     <= '0;
      mar_q    <= '0;
      mdr_q    <= '0;
      aluval_q <= '0;
      ccr_q    <= '0;
    end else begin
      case (ctrl.pc_sel)
        PC_INC:  pc_q <= pc_q + word_t'(4);
        PC_ALU:  pc_q <= alu_out; // branch or jump target
        default: pc_q <= pc_q;
      endcase
      if (ctrl.ir_write) ir_q <= readdata_i;
      if (ctrl.mar_sel == MAR_ALU) mar_q <= alu_out;
      case (ctrl.mdr_sel)
        MDR_LOAD: mdr_q <= load_data; // already lane aligned
        MDR_REG2: mdr_q <= data2;
        default:  mdr_q <= mdr_q;
      endcase
      aluval_q <= alu_out;
      if (ctrl.ccr_write) ccr_q <= alu_flags;
    end
  end

  control u_control (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .ack_i  (ack_i),
    .ir_i   (ir_q),
    .ccr_i  (ccr_q),
    .ctrl_o (ctrl),
    .cyc_o  (cyc_o),
    .we_o   (we_o),
    .halt_o (halt_o)
  );

  alu u_alu (
    .in1_i   (alu_in1),
    .in2_i   (alu_in2),
    .func_i  (ctrl.alu_func),
    .out_o   (alu_out),
    .flags_o (alu_flags)
  );

  register_file u_register_file (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .write_i      (ctrl.reg_write),
    .read1_i      (rs1),
    .read2_i      (read2_addr),
    .write_addr_i (rd),
    .write_data_i (reg_wdata),
    .data1_o      (data1),
    .data2_o      (data2)
  );

  bus_lanes u_bus_lanes (
    .size_i       (ctrl.mem_size),
    .addr_low_i   (address_o[1:0]),
    .store_i      (mdr_q),
    .readdata_i   (readdata_i),
    .cyc_i        (cyc_o),
    .byteenable_o (byteenable_o),
    .writedata_o  (writedata_o),
    .load_o       (load_data)
  );

endmodule

/* tb/bus_memory.sv */
module bus_memory import cpu_pkg::*; (
  input  logic       clk_i,
  input  logic       cyc_i,
  input  logic       we_i,
  input  word_t      address_i,
  input  logic [3:0] byteenable_i,
  input  word_t      writedata_i,
  output logic       ack_o,
  output word_t      readdata_o
);

  word_t mem [256];
  logic  busy;
  int    delay;

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hf000_0000 | (i << 2); // halt opcodes, tagged with their address
    end
    ack_o = 1'b0;
    readdata_o = '0;
    busy = 1'b0;
    delay = 0;
    void'($urandom(32'h25d5b811));
    forever begin
      @(negedge clk_i);
      if (ack_o) begin
        ack_o = 1'b0; // single cycle ack
        busy = 1'b0;
      end else if (cyc_i) begin
        if (!busy) begin
          delay = $urandom % 4;
          busy = 1'b1;
        end
        if (delay == 0) begin
          readdata_o = mem[address_i[9:2]];
          if (we_i) begin
            for (int b = 0; b < 4; b++) begin
              if (byteenable_i[b]) mem[address_i[9:2]][8*b +: 8] = writedata_i[8*b +: 8];
            end
          end
          ack_o = 1'b1;
        end else begin
          delay--;
        end
      end
    end
  end

endmodule

/* tb/tb_cpu_core.sv */
`include "cpu_macros.svh"

module tb_cpu_core import cpu_pkg::*; ();

  localparam word_t POISON_ADDR = 32'h0000_03f0;
  localparam word_t LOAD_WORD   = 32'hc3d4_e5f6; // preloaded at 0x300

  typedef struct packed {
    word_t      addr;
    logic [3:0] be;
    word_t      data;
  } store_t;

  logic       clk_i;
  logic       rst_i;
  logic       ack_i;
  word_t      readdata_i;
  word_t      address_o;
  word_t      writedata_o;
  logic [3:0] byteenable_o;
  logic       cyc_o;
  logic       we_o;
  logic       halt_o;

  store_t exp_q[$];
  string  name_q[$];
  word_t  pc_w;
  word_t  off;
  word_t  vals [16]; // register contents known at branch time
  logic   built;

  cpu_core uut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ack_i        (ack_i),
    .readdata_i   (readdata_i),
    .address_o    (address_o),
    .writedata_o  (writedata_o),
    .byteenable_o (byteenable_o),
    .cyc_o        (cyc_o),
    .we_o         (we_o),
    .halt_o       (halt_o)
  );

  bus_memory u_memory (
    .clk_i        (clk_i),
    .cyc_i        (cyc_o),
    .we_i         (we_o),
    .address_i    (address_o),
    .byteenable_i (byteenable_o),
    .writedata_i  (writedata_o),
    .ack_o        (ack_i),
    .readdata_o   (readdata_i)
  );

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "run stopped at first error");
  endtask

  function automatic word_t enc(input logic [3:0] op, input logic [3:0] fn,
                                input logic [3:0] rd, input logic [3:0] rs1,
                                input logic [15:0] imm);
    return {op, fn, imm[15:12], rd, rs1, imm[11:0]};
  endfunction

  // rs2 sits in the low immediate field
  function automatic word_t enc_rr(input logic [3:0] op, input logic [3:0] fn,
                                   input logic [3:0] rd, input logic [3:0] rs1,
                                   input logic [3:0] rs2);
    return enc(op, fn, rd, rs1, {4'h0, rs2, 8'h00});
  endfunction

  function automatic logic branch_taken(input logic [3:0] cond, input word_t a, input word_t b);
    case (cond)
      BR_ALWAYS: return 1'b1;
      BR_EQ:     return a == b;
      BR_NE:     return a != b;
      BR_LT:     return $signed(a) < $signed(b);
      BR_GE:     return !($signed(a) < $signed(b));
      BR_LTU:    return a < b;
      default:   return 1'b0;
    endcase
  endfunction

  task automatic emit(input word_t w);
    u_memory.mem[pc_w[9:2]] = w;
    pc_w = pc_w + 4;
  endtask

  task automatic expect_store(input word_t a, input logic [3:0] be, input word_t d,
                              input string name);
    exp_q.push_back('{addr: a, be: be, data: d});
    name_q.push_back(name);
  endtask

  // word store of rd at the next free slot of the result area
  task automatic store_result(input logic [3:0] rd, input word_t d, input string name);
    emit(enc(OP_STORE, SIZE_WORD, rd, 4'd1, off[15:0]));
    expect_store(32'h200 + off, 4'b1111, d, name);
    off = off + 4;
  endtask

  task automatic build_program();
    word_t      a;
    word_t      b;
    word_t      r;
    word_t      p;
    logic [3:0] cond [11];
    logic [3:0] ra [11];
    logic [3:0] rb [11];
    cond = '{BR_ALWAYS, BR_EQ, BR_EQ, BR_NE, BR_NE, BR_LT, BR_LT, BR_GE, BR_GE, BR_LTU, BR_LTU};
    ra   = '{4'd2, 4'd2, 4'd3, 4'd3, 4'd2, 4'd10, 4'd3, 4'd3, 4'd10, 4'd3, 4'd10};
    rb   = '{4'd2, 4'd2, 4'd2, 4'd2, 4'd2, 4'd3, 4'd10, 4'd10, 4'd3, 4'd10, 4'd3};
    pc_w = `CPU_RESET_PC;
    off = 0;
    vals = '{default: '0};
    a = 32'h9abc;
    b = 32'h7;
    vals[2] = a;
    vals[3] = b;
    vals[10] = 32'hffff_ffff;
    u_memory.mem[8'hc0] = LOAD_WORD;
    emit(enc(OP_LUI, 0, 1, 0, 16'h0200)); // result area base
    emit(enc(OP_LUI, 0, 2, 0, 16'h9abc));
    emit(enc(OP_LUI, 0, 3, 0, 16'h0007));
    emit(enc(OP_LUI, 0, 5, 0, 16'ha1b2));
    emit(enc(OP_LUI, 0, 6, 0, 16'h0300));
    emit(enc(OP_ALUI, ALU_ADD, 10, 0, 16'hffff)); // r10 = -1
    for (int f = 0; f < 7; f++) begin
      if (f == ALU_SUB) begin
        emit(enc_rr(OP_ALU, 4'(f), 4, 3, 2)); // borrow case
        r = b - a;
      end else begin
        emit(enc_rr(OP_ALU, 4'(f), 4, 2, 3));
        case (f)
          ALU_ADD: r = a + b;
          ALU_AND: r = a & b;
          ALU_OR:  r = a | b;
          ALU_XOR: r = a ^ b;
          ALU_SHL: r = a << b;
          default: r = a >> b;
        endcase
      end
      store_result(4, r, $sformatf("alu func %0d", f));
    end
    emit(enc(OP_ALUI, ALU_ADD, 4, 2, 16'hfffe));
    store_result(4, a - 2, "alu immediate");
    store_result(5, 32'ha1b2, "load immediate");
    for (int k = 0; k < 4; k++) begin
      emit(enc(OP_STORE, SIZE_BYTE, 5, 1, 16'(8'h40 + k)));
      expect_store(32'h240 + k, 4'b0001 << k, 32'hb2 << (8 * k), $sformatf("byte lane %0d", k));
    end
    emit(enc(OP_STORE, SIZE_HALF, 5, 1, 16'h0050));
    expect_store(32'h250, 4'b0011, 32'h0000_a1b2, "half low");
    emit(enc(OP_STORE, SIZE_HALF, 5, 1, 16'h0052));
    expect_store(32'h252, 4'b1100, 32'ha1b2_0000, "half high");
    off = 32'h60;
    emit(enc(OP_LOAD, SIZE_BYTE, 7, 6, 16'h0001));
    store_result(7, (LOAD_WORD >> 8) & 32'hff, "load byte");
    emit(enc(OP_LOAD, SIZE_HALF, 7, 6, 16'h0002));
    store_result(7, LOAD_WORD >> 16, "load half");
    emit(enc(OP_LOAD, SIZE_WORD, 7, 6, 16'h0000));
    store_result(7, LOAD_WORD, "load word");
    for (int c = 0; c < 11; c++) begin
      emit(enc_rr(OP_CMP, 0, 0, ra[c], rb[c]));
      emit(enc(OP_BRANCH, cond[c], 0, 0, 16'd4)); // skips one instruction
      if (branch_taken(cond[c], vals[ra[c]], vals[rb[c]])) begin
        emit(enc(OP_STORE, SIZE_WORD, 2, 1, 16'h01f0));
      end else begin
        store_result(2, a, $sformatf("branch %0d fall through", c));
      end
      store_result(2, a, $sformatf("branch %0d join", c));
    end
    p = pc_w;
    emit(enc(OP_LUI, 0, 11, 0, p[15:0] + 16'd12));
    emit(enc(OP_JUMP, 0, 0, 11, 16'h0000));
    emit(enc(OP_STORE, SIZE_WORD, 2, 1, 16'h01f0));
    store_result(2, a, "jump target");
    emit(32'hf000_0000); // halt
  endtask

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    built = 1'b0;
    rst_i = 1'b0;
    #1;
    rst_i = 1'b1;
    build_program();
    built = 1'b1;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    assert (!cyc_o && !we_o && !halt_o)
      else report_error("bus strobes or halt high right after reset");
    @(posedge clk_i iff cyc_o);
    assert (address_o == `CPU_RESET_PC)
      else report_error($sformatf("error first fetch: expected %h actual %h",
                                  `CPU_RESET_PC, address_o));
    assert (!we_o) else report_error("first bus cycle is a write");
    wait (halt_o);
    repeat (20) @(posedge clk_i); // halt must hold with the bus idle
    if (exp_q.size() == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      report_error($sformatf("%0d expected stores never appeared, next %s",
                             exp_q.size(), name_q[0]));
    end
  end

  initial begin
    wait (built);
    #(longint'(4) * 40 * 4 * (pc_w >> 2));
    report_error("watchdog expired, the core hangs");
  end

  always @(posedge clk_i) begin
    store_t e;
    string  n;
    if (!rst_i && cyc_o && ack_i && we_o) begin
      assert (exp_q.size() > 0)
        else report_error($sformatf("unexpected store at %h", address_o));
      e = exp_q.pop_front();
      n = name_q.pop_front();
      assert (address_o == e.addr)
        else report_error($sformatf("error %s address: expected %h actual %h",
                                    n, e.addr, address_o));
      assert (byteenable_o == e.be)
        else report_error($sformatf("error %s byteenable: expected %b actual %b",
                                    n, e.be, byteenable_o));
      assert (writedata_o == e.data)
        else report_error($sformatf("error %s data: expected %h actual %h",
                                    n, e.data, writedata_o));
    end
  end

  reset_quiet: assert property (@(posedge clk_i) rst_i |-> !cyc_o && !we_o && !halt_o)
    else report_error("bus strobes or halt high during reset");

  bus_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    cyc_o && !ack_i |=> $stable(address_o) && $stable(we_o) &&
                        $stable(byteenable_o) && $stable(writedata_o))
    else report_error("bus signals changed while waiting for ack");

  no_poison: assert property (@(posedge clk_i) disable iff (rst_i)
    cyc_o && we_o |-> address_o != POISON_ADDR)
    else report_error("store on a path that should have been skipped");

  halt_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
    halt_o |-> !cyc_o ##1 halt_o)
    else report_error("halt dropped or bus cycle started after halt");

endmodule

/* sources.f */
+incdir+common
common/cpu_pkg.sv
hdl/alu.sv
hdl/register_file.sv
hdl/bus_lanes.sv
control/control.sv
hdl/cpu_core.sv
tb/bus_memory.sv
tb/tb_cpu_core.sv
